// File: top8227.f
source/cpuOpcodePkg.sv
source/cpuControlPkg.sv
source/decoder.sv
source/instructionLoader.sv
source/timingSequencer.sv
source/internalDataflow.sv
source/top8227.sv
verification/top8227_asserts.sv
verification/top8227Tb.sv

// File: Bender.yml
package:
  name: top8227

sources:
  - source/cpuOpcodePkg.sv
  - source/cpuControlPkg.sv
  - source/decoder.sv
  - source/instructionLoader.sv
  - source/timingSequencer.sv
  - source/internalDataflow.sv
  - source/top8227.sv
  - target: test
    files:
      - verification/top8227_asserts.sv
      - verification/top8227Tb.sv

// File: verification/top8227Tb.sv
`timescale 1ns/1ps

module top8227Tb;
    import cpuOpcodePkg::*;
    import cpuControlPkg::*;

    localparam int                      slowPulseDivide     = 2;
    localparam logic [addressWidth-1:0] resetProgramCounter = 16'h0200;
    localparam int                      numRows             = 9;

    typedef struct {
        string                   name;
        logic [dataWidth-1:0]    opcodeByte;
        logic [addressWidth-1:0] operand;
        logic [addressWidth-1:0] storeAddress;
    } rowT;

    logic                        clk;
    logic                        rst = 1'b1;
    logic                        ready = 1'b1;
    logic [dataWidth-1:0]        dataBusInput = '0;
    logic [dataWidth-1:0]        dataBusOutput;
    logic [addressHalfWidth-1:0] addressBusHigh;
    logic [addressHalfWidth-1:0] addressBusLow;
    logic                        sync;
    logic                        readNotWrite;
    logic [addressWidth-1:0]     busAddress;

    logic [dataWidth-1:0]    memory [0:2**addressWidth-1];
    rowT                     programTable [numRows];
    logic [dataWidth-1:0]    expectedData [numRows];
    logic [addressWidth-1:0] fetchAddressQ [$];
    logic [dataWidth-1:0]    fetchOpcodeQ [$];
    logic [addressWidth-1:0] storeAddressQ [$];
    logic [dataWidth-1:0]    storeDataQ [$];
    logic [addressWidth-1:0] asmPc;
    logic [dataWidth-1:0]    accModel;
    logic                    carryModel;
    opcodeT                  heldOpcode = opNop; // the opcode register resets to NOP
    integer                  seed = 32'h7f86;
    int errorCount = 0;
    int passCount = 0;
    int failCount = 0;
    int fetchIndex = 0;
    int watchdogCycles = 0;

    assign busAddress = {addressBusHigh, addressBusLow};

    top8227 #(
        .slowPulseDivide    (slowPulseDivide),
        .resetProgramCounter(resetProgramCounter)
    ) dut0 (
        .clk           (clk),
        .rst           (rst),
        .ready         (ready),
        .dataBusInput  (dataBusInput),
        .dataBusOutput (dataBusOutput),
        .addressBusHigh(addressBusHigh),
        .addressBusLow (addressBusLow),
        .sync          (sync),
        .readNotWrite  (readNotWrite)
    );

    bind top8227 top8227_asserts busAsserts (
        .clk           (clk),
        .rst           (rst),
        .ready         (ready),
        .sync          (sync),
        .readNotWrite  (readNotWrite),
        .addressBusHigh(addressBusHigh),
        .addressBusLow (addressBusLow)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // memory model and bus monitors
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin
        if (readNotWrite) begin
            ready = ($random(seed) & 3) != 0; // a read stalls about one time in four
        end else begin
            ready = 1'b0; // a write has to go ahead even with ready low
        end
        dataBusInput = memory[busAddress];
    end

    // the store completes on the edge where the core's enable is high
    always @(posedge clk) begin
        if (!rst && dut0.enableFFs && !readNotWrite) begin
            storeAddressQ.push_back(busAddress);
            storeDataQ.push_back(dataBusOutput);
        end
    end

    // the opcode register still holds the previous fetch when the next one starts
    always @(posedge clk) begin
        if (!rst && sync && fetchAddressQ.size() > 0) begin
            checkOpcode($sformatf("opcode before fetch %0d", fetchIndex), heldOpcode,
                        dut0.opcodeCurrentValue);
            checkAddress($sformatf("fetch %0d", fetchIndex), fetchAddressQ.pop_front(),
                         busAddress);
            heldOpcode = opcodeT'(fetchOpcodeQ.pop_front());
            fetchIndex++;
        end
    end

    task automatic checkByte(input string name, input logic [dataWidth-1:0] expected, actual);
        if (actual !== expected) begin
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic checkAddress(input string name, input logic [addressWidth-1:0] expected, actual);
        if (actual !== expected) begin
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic checkOpcode(input string name, input opcodeT expected, actual);
        if (actual !== expected) begin
            $display("[FAIL] %s expected opcode %h actual %h", name, expected, actual);
            errorCount++;
        end
    endtask

    function automatic int operandBytes(input logic [dataWidth-1:0] op);
        case (op)
            opLdaImmediate, opAdcImmediate, opAndImmediate: return 1;
            opLdaAbsolute, opStaAbsolute, opJmpAbsolute:    return 2;
            default:                                        return 0;
        endcase
    endfunction

    function automatic int busCycles(input logic [dataWidth-1:0] op);
        if (op == opJmpAbsolute) begin
            return 3;
        end
        return (operandBytes(op) == 2) ? 4 : 2;
    endfunction

    // places one instruction at asmPc and notes where its opcode will be fetched
    task automatic emitInstruction(input logic [dataWidth-1:0] op,
                                   input logic [addressWidth-1:0] operand);
        fetchAddressQ.push_back(asmPc);
        fetchOpcodeQ.push_back(op);
        memory[asmPc] = op;
        for (int i = 0; i < operandBytes(op); i++) begin
            memory[asmPc + 16'(i + 1)] = operand[8*i +: 8];
        end
        asmPc = (op == opJmpAbsolute) ? operand : asmPc + 16'(operandBytes(op) + 1);
    endtask

    task automatic applyModel(input logic [dataWidth-1:0] op,
                              input logic [addressWidth-1:0] operand);
        logic [dataWidth:0] sum;
        case (op)
            opLdaImmediate: accModel = operand[dataWidth-1:0];
            opLdaAbsolute:  accModel = memory[operand];
            opAndImmediate: accModel = accModel & operand[dataWidth-1:0];
            opAdcImmediate: begin
                sum        = {1'b0, accModel} + {1'b0, operand[dataWidth-1:0]} + 9'(carryModel);
                accModel   = sum[dataWidth-1:0];
                carryModel = sum[dataWidth];
            end
            default: ; // stores, jumps and NOPs leave A and C alone
        endcase
    endtask

    initial begin
        int cycleBudget;
        int rowLimit;
        int waited;
        int errorsBefore;
        for (int a = 0; a < 2**addressWidth; a++) begin
            memory[a] = 8'(a >> 8) ^ 8'(a) ^ 8'hA5;
        end
        programTable = '{
            '{"ldaImmediate", opLdaImmediate, 16'h005A, 16'h0300},
            '{"adcNoCarry",   opAdcImmediate, 16'h0010, 16'h0301},
            '{"adcWrap",      opAdcImmediate, 16'h00C0, 16'h0302},
            '{"adcCarryIn",   opAdcImmediate, 16'h0001, 16'h0303},
            '{"andMask",      opAndImmediate, 16'h000F, 16'h0304},
            '{"ldaAbsolute",  opLdaAbsolute,  16'h0480, 16'h0305},
            '{"jmpAbsolute",  opJmpAbsolute,  16'h0260, 16'h0306},
            '{"nop",          opNop,          16'h0000, 16'h0307},
            '{"unknownOp",    8'hFF,          16'h0000, 16'h0308}
        };
        asmPc       = resetProgramCounter;
        accModel    = '0;
        carryModel  = 1'b0;
        cycleBudget = 0;
        foreach (programTable[r]) begin
            emitInstruction(programTable[r].opcodeByte, programTable[r].operand);
            applyModel(programTable[r].opcodeByte, programTable[r].operand);
            expectedData[r] = accModel;
            emitInstruction(opStaAbsolute, programTable[r].storeAddress);
            cycleBudget += busCycles(programTable[r].opcodeByte) + busCycles(opStaAbsolute);
        end
        emitInstruction(opJmpAbsolute, asmPc); // park on a jump to itself
        watchdogCycles = (cycleBudget + 8) * slowPulseDivide * 4 + 100;

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        foreach (programTable[r]) begin
            rowLimit = (busCycles(programTable[r].opcodeByte) + 4) * slowPulseDivide * 4 + 20;
            waited   = 0;
            while (storeAddressQ.size() == 0 && waited < rowLimit) begin
                @(negedge clk);
                waited++;
            end
            if (storeAddressQ.size() == 0) begin
                $display("%s: no store arrived within %0d clock cycles", programTable[r].name,
                         rowLimit);
                errorCount++;
                failCount++;
            end else begin
                errorsBefore = errorCount;
                checkAddress(programTable[r].name, programTable[r].storeAddress,
                             storeAddressQ.pop_front());
                checkByte(programTable[r].name, expectedData[r], storeDataQ.pop_front());
                if (errorCount == errorsBefore) begin
                    $display("[PASS] %s stored %h", programTable[r].name, expectedData[r]);
                    passCount++;
                end else begin
                    failCount++;
                end
            end
        end

        if (fetchIndex < 2 * numRows) begin
            $display("only %0d of %0d opcode fetches were marked by sync", fetchIndex,
                     2 * numRows);
            errorCount++;
        end

        $display("rows %0d passed %0d failed %0d, check failures %0d, assertion failures %0d",
                 numRows, passCount, failCount, errorCount, dut0.busAsserts.violationCount);
        if (errorCount == 0 && dut0.busAsserts.violationCount == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // four times the stall-free clock count leaves room for ready stalls
    initial begin
        wait (watchdogCycles > 0);
        repeat (watchdogCycles) @(posedge clk);
        $display("watchdog: the run did not finish within %0d clock cycles", watchdogCycles);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: verification/top8227_asserts.sv
`timescale 1ns/1ps

module top8227_asserts (
    input logic                                        clk,
    input logic                                        rst,
    input logic                                        ready,
    input logic                                        sync,
    input logic                                        readNotWrite,
    input logic [cpuControlPkg::addressHalfWidth-1:0] addressBusHigh,
    input logic [cpuControlPkg::addressHalfWidth-1:0] addressBusLow
);
    int violationCount = 0;

    // a stalled read keeps its address for the memory
    stallHoldsAddress: assert property (@(posedge clk) disable iff (rst)
        (!ready && readNotWrite) |=> $stable({addressBusHigh, addressBusLow}))
    else begin
        $error("address moved while a read was stalled by ready");
        violationCount++;
    end

    fetchIsRead: assert property (@(posedge clk) sync |-> readNotWrite)
    else begin
        $error("opcode fetch marked by sync is not a read");
        violationCount++;
    end

    readAroundReset: assert property (@(posedge clk) (rst || $past(rst)) |-> readNotWrite)
    else begin
        $error("write cycle during or right after reset");
        violationCount++;
    end

endmodule

// File: source/top8227.sv
`timescale 1ns/1ps

module top8227 #(
    parameter int                                     slowPulseDivide     = 2,
    parameter logic [cpuControlPkg::addressWidth-1:0] resetProgramCounter = 16'h0200
) (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic                                        ready,
    input  logic [cpuControlPkg::dataWidth-1:0]        dataBusInput,
    output logic [cpuControlPkg::dataWidth-1:0]        dataBusOutput,
    output logic [cpuControlPkg::addressHalfWidth-1:0] addressBusHigh,
    output logic [cpuControlPkg::addressHalfWidth-1:0] addressBusLow,
    output logic                                        sync,
    output logic                                        readNotWrite
);
    import cpuOpcodePkg::*;
    import cpuControlPkg::*;

    localparam int pulseCountWidth = (slowPulseDivide > 1) ? $clog2(slowPulseDivide) : 1;

    opcodeT                      opcodeCurrentValue;
    instructionCodeT             instructionCode;
    addressingCodeT              addressingCode;
    logic                        loadNextInstruction;
    logic [numFlags-1:0]         preFlags;
    logic [numFlags-1:0]         flags;
    logic                        enableFFs;
    logic                        slowPulse;
    logic [pulseCountWidth-1:0]  pulseCount;

    // one bus cycle every slowPulseDivide clocks so memory has time to answer
    always_ff @(posedge clk) begin
        if (rst || slowPulse) begin
            pulseCount <= '0;
        end else begin
            pulseCount <= pulseCount + 1'b1;
        end
    end

    assign slowPulse    = (pulseCount == pulseCountWidth'(slowPulseDivide - 1));
    assign readNotWrite = ~preFlags[setWrite];
    assign enableFFs    = slowPulse & (ready | ~readNotWrite); // writes ignore ready
    assign sync         = flags[endInstruction];

    always_comb begin
        if (enableFFs) begin
            flags = preFlags;
        end else begin
            flags = '0;
        end
    end

    instructionLoader instructionLoader (
        .clk                (clk),
        .rst                (rst),
        .enableFFs          (enableFFs),
        .loadNextInstruction(loadNextInstruction),
        .dataBusInput       (dataBusInput),
        .nextInstruction    (opcodeCurrentValue)
    );

    decoder decoder (
        .opcode         (opcodeCurrentValue),
        .instructionCode(instructionCode),
        .addressingCode (addressingCode)
    );

    timingSequencer timingSequencer (
        .clk                (clk),
        .rst                (rst),
        .enableFFs          (enableFFs),
        .instructionCode    (instructionCode),
        .addressingCode     (addressingCode),
        .preFlags           (preFlags),
        .loadNextInstruction(loadNextInstruction)
    );

    internalDataflow #(
        .resetProgramCounter(resetProgramCounter)
    ) internalDataflow (
        .clk           (clk),
        .rst           (rst),
        .enableFFs     (enableFFs),
        .flags         (flags),
        .dataBusInput  (dataBusInput),
        .dataBusOutput (dataBusOutput),
        .addressBusLow (addressBusLow),
        .addressBusHigh(addressBusHigh)
    );

endmodule

// File: source/internalDataflow.sv
`timescale 1ns/1ps

module internalDataflow #(
    parameter logic [cpuControlPkg::addressWidth-1:0] resetProgramCounter = 16'h0200
) (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic                                        enableFFs,
    input  logic [cpuControlPkg::numFlags-1:0]         flags,
    input  logic [cpuControlPkg::dataWidth-1:0]        dataBusInput,
    output logic [cpuControlPkg::dataWidth-1:0]        dataBusOutput,
    output logic [cpuControlPkg::addressHalfWidth-1:0] addressBusLow,
    output logic [cpuControlPkg::addressHalfWidth-1:0] addressBusHigh
);
    import cpuControlPkg::*;

    localparam int statusCarry    = 0;
    localparam int statusZero     = 1;
    localparam int statusNegative = 2;

    logic [dataWidth-1:0]        accumulator;
    logic [2:0]                  statusRegister;
    logic [addressWidth-1:0]     programCounter;
    logic [addressWidth-1:0]     nextProgramCounter;
    logic [addressHalfWidth-1:0] addressLatchLow;
    logic [addressHalfWidth-1:0] addressLatchHigh;
    logic                        useLatchedAddress;
    logic [dataWidth-1:0]        dataOutRegister;
    logic [dataWidth:0]          aluSum;
    logic [dataWidth-1:0]        aluResult;
    logic [addressWidth-1:0]     busAddress;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ALU
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign aluSum = {1'b0, accumulator} + {1'b0, dataBusInput}
                  + {{dataWidth{1'b0}}, statusRegister[statusCarry]};

    always_comb begin
        if (flags[aluAdd]) begin
            aluResult = aluSum[dataWidth-1:0];
        end else if (flags[aluAnd]) begin
            aluResult = accumulator & dataBusInput;
        end else begin
            aluResult = dataBusInput; // plain load
        end
    end

    // JMP takes its high byte straight off the bus in the same cycle it is latched
    always_comb begin
        nextProgramCounter = programCounter;
        if (flags[loadPcFromLatch]) begin
            nextProgramCounter = {dataBusInput, addressLatchLow};
        end else if (flags[incrementPc]) begin
            nextProgramCounter = programCounter + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            accumulator       <= '0;
            statusRegister    <= '0;
            programCounter    <= resetProgramCounter;
            useLatchedAddress <= 1'b0;
            dataOutRegister   <= '0;
        end else if (enableFFs) begin
            programCounter    <= nextProgramCounter;
            useLatchedAddress <= flags[driveLatchedAddress];
            if (flags[driveLatchedAddress]) begin
                dataOutRegister <= accumulator; // ready before a possible store cycle
            end
            if (flags[loadAccumulator]) begin
                accumulator                    <= aluResult;
                statusRegister[statusZero]     <= (aluResult == '0);
                statusRegister[statusNegative] <= aluResult[dataWidth-1];
                if (flags[aluAdd]) begin
                    statusRegister[statusCarry] <= aluSum[dataWidth];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enableFFs && flags[latchAddressLow]) begin
            addressLatchLow <= dataBusInput;
        end
        if (enableFFs && flags[latchAddressHigh]) begin
            addressLatchHigh <= dataBusInput;
        end
    end

    // address only moves on an enabled edge, so it holds through a stall
    assign busAddress     = useLatchedAddress ? {addressLatchHigh, addressLatchLow}
                                              : programCounter;
    assign addressBusLow  = busAddress[addressHalfWidth-1:0];
    assign addressBusHigh = busAddress[addressWidth-1:addressHalfWidth];
    assign dataBusOutput  = dataOutRegister;

endmodule

// File: source/timingSequencer.sv
`timescale 1ns/1ps

module timingSequencer (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 enableFFs,
    input  cpuOpcodePkg::instructionCodeT        instructionCode,
    input  cpuOpcodePkg::addressingCodeT         addressingCode,
    output logic [cpuControlPkg::numFlags-1:0]  preFlags,
    output logic                                 loadNextInstruction
);
    import cpuOpcodePkg::*;
    import cpuControlPkg::*;

    cycleCountT cycleIndex;
    cycleCountT lastCycle;

    assign lastCycle = cycleCount(instructionCode, addressingCode) - cycleCountT'(1);

    // the opcode fetch closes the previous instruction and loads the next one
    assign loadNextInstruction = preFlags[fetchOpcode];

    always_ff @(posedge clk) begin
        if (rst) begin
            cycleIndex <= '0;
        end else if (enableFFs) begin
            if (cycleIndex == lastCycle) begin
                cycleIndex <= '0;
            end else begin
                cycleIndex <= cycleIndex + cycleCountT'(1);
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // flags for the current bus cycle
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        preFlags = '0;
        case (cycleIndex)
            3'd0: begin
                preFlags[fetchOpcode]    = 1'b1;
                preFlags[incrementPc]    = 1'b1;
                preFlags[endInstruction] = 1'b1;
            end
            3'd1: begin
                if (addressingCode == aImmediate) begin
                    preFlags[incrementPc]     = 1'b1;
                    preFlags[loadAccumulator] = 1'b1;
                    preFlags[aluAdd]          = (instructionCode == iAdd);
                    preFlags[aluAnd]          = (instructionCode == iAnd);
                end else if (addressingCode == aAbsolute) begin
                    preFlags[latchAddressLow] = 1'b1;
                    preFlags[incrementPc]     = 1'b1;
                end
                // implied only spends the cycle reading the next byte
            end
            3'd2: begin
                if (addressingCode == aAbsolute) begin
                    preFlags[latchAddressHigh] = 1'b1;
                    if (instructionCode == iJump) begin
                        preFlags[loadPcFromLatch] = 1'b1;
                    end else begin
                        preFlags[incrementPc]         = 1'b1;
                        preFlags[driveLatchedAddress] = 1'b1;
                    end
                end
            end
            3'd3: begin
                preFlags[loadAccumulator] = (instructionCode == iLoad);
                preFlags[setWrite]        = (instructionCode == iStore); // never stalled by ready
            end
            default: begin
                preFlags = '0;
            end
        endcase
    end

endmodule

// File: source/instructionLoader.sv
`timescale 1ns/1ps

module instructionLoader (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 enableFFs,
    input  logic                                 loadNextInstruction,
    input  logic [cpuControlPkg::dataWidth-1:0] dataBusInput,
    output cpuOpcodePkg::opcodeT                 nextInstruction
);
    import cpuOpcodePkg::*;

    // a NOP after reset makes the sequencer start on a plain opcode fetch
    always_ff @(posedge clk) begin
        if (rst) begin
            nextInstruction <= opNop;
        end else if (enableFFs && loadNextInstruction) begin
            nextInstruction <= opcodeT'(dataBusInput); // unknown bytes are kept as read
        end
    end

endmodule

// File: source/decoder.sv
`timescale 1ns/1ps

module decoder (
    input  cpuOpcodePkg::opcodeT         opcode,
    output cpuOpcodePkg::instructionCodeT instructionCode,
    output cpuOpcodePkg::addressingCodeT  addressingCode
);
    import cpuOpcodePkg::*;

    always_comb begin
        case (opcode)
            opLdaImmediate: begin
                instructionCode = iLoad;
                addressingCode  = aImmediate;
            end
            opLdaAbsolute: begin
                instructionCode = iLoad;
                addressingCode  = aAbsolute;
            end
            opStaAbsolute: begin
                instructionCode = iStore;
                addressingCode  = aAbsolute;
            end
            opAdcImmediate: begin
                instructionCode = iAdd;
                addressingCode  = aImmediate;
            end
            opAndImmediate: begin
                instructionCode = iAnd;
                addressingCode  = aImmediate;
            end
            opJmpAbsolute: begin
                instructionCode = iJump;
                addressingCode  = aAbsolute;
            end
            default: begin // NOP and every unsupported byte
                instructionCode = iNop;
                addressingCode  = aImplied;
            end
        endcase
    end

endmodule

// File: source/cpuControlPkg.sv
package cpuControlPkg;

    localparam int dataWidth        = 8;
    localparam int addressWidth     = 16;
    localparam int addressHalfWidth = addressWidth / 2;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // positions of the control flags inside the flag vector
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [3:0] {
        fetchOpcode,
        incrementPc,
        latchAddressLow,
        latchAddressHigh,
        driveLatchedAddress, // next bus cycle uses the operand address
        loadAccumulator,
        aluAdd,
        aluAnd,
        setWrite,
        loadPcFromLatch,
        endInstruction
    } flagIndexT;

    localparam int numFlags = int'(endInstruction) + 1;

endpackage

// File: source/cpuOpcodePkg.sv
package cpuOpcodePkg;

    // opcode values the core understands, anything else decodes as a NOP
    typedef enum logic [7:0] {
        opLdaImmediate = 8'hA9,
        opLdaAbsolute  = 8'hAD,
        opStaAbsolute  = 8'h8D,
        opAdcImmediate = 8'h69,
        opAndImmediate = 8'h29,
        opJmpAbsolute  = 8'h4C,
        opNop          = 8'hEA
    } opcodeT;

    typedef enum logic [2:0] {
        iLoad,
        iStore,
        iAdd,
        iAnd,
        iJump,
        iNop
    } instructionCodeT;

    typedef enum logic [1:0] {
        aImplied,
        aImmediate,
        aAbsolute
    } addressingCodeT;

    typedef logic [2:0] cycleCountT;

    // bus cycles per instruction, counting the overlapped opcode fetch
    function automatic cycleCountT cycleCount(instructionCodeT code, addressingCodeT mode);
        if (mode != aAbsolute) begin
            return cycleCountT'(2);
        end
        return (code == iJump) ? cycleCountT'(3) : cycleCountT'(4);
    endfunction

endpackage
